//--- Makefile
# Verilator build for the repacking path testbench

TOP = repack_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f sources.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sources.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

//--- sources.f
verilog/repack_pkg.sv
verilog/beat_splitter.sv
verilog/word_fifo.sv
verilog/beat_reassembler.sv
verilog/repack_top.sv
test/repack_assert.sv
test/repack_tb.sv

//--- test/repack_assert.sv
// Concurrent checks on the repacking top level attached by bind.
// Covers output hold under back-pressure, FIFO overflow and reset state.

`timescale 1ns/1ps

module repack_assert
    import repack_pkg::*;
(
    input logic         clk,
    input logic         reset,
    input logic         in_ready,
    input logic         out_valid,
    input logic         out_ready,
    input stream_beat_t out_beat,
    input logic         wr_en,
    input logic         fifo_full
);

    // Failed assertions so far
    int failures = 0;

    // Stalled output beat must hold
    assert property (@(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=> ($stable(out_valid) && $stable(out_beat)))
        else
        begin
            $error("out_valid or out_beat changed while out_ready was low");
            failures++;
        end

    // Splitter never writes into a full FIFO
    assert property (@(posedge clk) disable iff (reset) !(wr_en && fifo_full))
        else
        begin
            $error("word written while the FIFO was full");
            failures++;
        end

    // Input closed once reset has been seen
    assert property (@(posedge clk) reset |=> !in_ready)
        else
        begin
            $error("in_ready high during reset");
            failures++;
        end

endmodule

bind repack_top repack_assert u_assert (
    .clk       (clk),
    .reset     (reset),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_beat  (out_beat),
    .wr_en     (wr_en),
    .fifo_full (u_fifo.full)
);

//--- test/repack_tb.sv
// Directed testbench for repack_top. Sends packets of random beats, keeps the
// sent beats in a queue and checks every accepted output beat against it.
// Run through the Makefile; closes with the error count and a verdict line.

`timescale 1ns/1ps

module repack_tb
    import repack_pkg::*;
();

    localparam logic [31:0] LFSR_SEED = 32'hd53322bb;
    localparam int PACKETS        = 40;
    // Upper bound on beats over all tests
    localparam int MAX_BEATS      = 3 + 6 + 2 * PACKETS * 6 + 2 + 3;
    localparam int TIMEOUT_CYCLES = 20 * MAX_BEATS + 400;

    // out_ready modes
    localparam int READY_ALWAYS = 0;
    localparam int READY_RANDOM = 1;
    localparam int READY_HOLD   = 2;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  in_valid;
    stream_beat_t          in_beat;
    logic                  out_ready;
    logic                  in_ready;
    logic                  out_valid;
    stream_beat_t          out_beat;
    logic [BEAT_BYTES-1:0] out_keep;
    logic [31:0]           out_beat_count;

    // Scoreboard and bookkeeping
    stream_beat_t expected_q[$];
    int           errors = 0;
    int           checks = 0;
    int           observed_count = 0;
    int           ready_mode = READY_ALWAYS;
    logic         stall_seen = 1'b0;
    logic [31:0]  data_lfsr = LFSR_SEED;
    logic [31:0]  ready_lfsr = LFSR_SEED;

    repack_top dut (
        .clk            (clk),
        .reset          (reset),
        .in_valid       (in_valid),
        .in_beat        (in_beat),
        .out_ready      (out_ready),
        .in_ready       (in_ready),
        .out_valid      (out_valid),
        .out_beat       (out_beat),
        .out_keep       (out_keep),
        .out_beat_count (out_beat_count)
    );

    always #4 clk = ~clk;

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            data_lfsr = lfsr_next(data_lfsr);
            r = {r[30:0], data_lfsr[0]};
        end
        return r;
    endfunction

    function automatic stream_beat_t make_beat(input logic last, input logic [4:0] count);
        stream_beat_t b;
        for (int i = 0; i < 8; i++)
            b.data[32*i +: 32] = random_bits(32);
        b.last  = last;
        b.count = count;
        return b;
    endfunction

    // Bytes 0 to count valid
    function automatic logic [31:0] keep_mask(input logic [4:0] count);
        logic [31:0] mask;
        mask = '0;
        for (int i = 0; i <= int'(count); i++)
            mask[i] = 1'b1;
        return mask;
    endfunction

    task automatic check_value(input string name, input logic [255:0] got,
                               input logic [255:0] expected);
        checks++;
        if (got !== expected)
        begin
            errors++;
            $display("mismatch %s: got %h expected %h", name, got, expected);
        end
    endtask

    // Starts on a falling edge and returns on the falling edge after the take
    task automatic send_beat(input stream_beat_t b);
        int waited;
        waited   = 0;
        in_valid = 1'b1;
        in_beat  = b;
        while (!in_ready)
        begin
            waited++;
            @(negedge clk);
        end
        // Longer than the one-cycle second-word gap means the FIFO backed up
        if (waited >= 2)
            stall_seen = 1'b1;
        expected_q.push_back(b);
        @(negedge clk);
    endtask

    task automatic send_packet(input int beats, input logic [4:0] last_count);
        for (int i = 0; i < beats; i++)
            send_beat(make_beat(i == beats - 1, (i == beats - 1) ? last_count : 5'd31));
    endtask

    task automatic idle_input;
        in_valid = 1'b0;
        in_beat  = '0;
    endtask

    task automatic wait_drain;
        while (expected_q.size() != 0)
            @(negedge clk);
        repeat (4) @(negedge clk);
        check_value("out_valid", out_valid, 1'b0);
        check_value("out_beat_count", out_beat_count, observed_count);
    endtask

    //////////////////////////////////////////////////
    // Output side
    //////////////////////////////////////////////////

    always @(negedge clk)
    begin
        if (ready_mode == READY_RANDOM)
        begin
            ready_lfsr = lfsr_next(ready_lfsr);
            out_ready  = ready_lfsr[0];
        end
        else
            out_ready = (ready_mode == READY_ALWAYS);
    end

    // Monitor pops one queue entry per accepted beat
    always @(posedge clk)
    begin : monitor
        stream_beat_t exp_beat;
        if (!reset && out_valid && out_ready)
        begin
            observed_count++;
            if (expected_q.size() == 0)
            begin
                errors++;
                $display("output beat accepted with no input beat waiting for it");
            end
            else
            begin
                exp_beat = expected_q.pop_front();
                check_value("out_beat.data", out_beat.data, exp_beat.data);
                check_value("out_beat.last", out_beat.last, exp_beat.last);
                check_value("out_beat.count", out_beat.count, exp_beat.count);
                check_value("out_keep", out_keep, keep_mask(exp_beat.count));
            end
        end
    end

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic test_full_packet;
        send_packet(3, 5'd31);
        idle_input();
        wait_drain();
    endtask

    // Short packets end early in a group and need flush words
    task automatic test_flush_words;
        send_packet(1, 5'd5);
        send_packet(2, 5'd17);
        send_packet(1, 5'd0);
        send_packet(2, 5'd30);
        idle_input();
        wait_drain();
    endtask

    task automatic test_random_packets(input int mode);
        int          len;
        logic [31:0] cnt;
        ready_mode <= mode;
        stall_seen = 1'b0;
        for (int p = 0; p < PACKETS; p++)
        begin
            len = 1 + int'(random_bits(3) % 6);
            cnt = random_bits(5);
            send_packet(len, cnt[4:0]);
        end
        idle_input();
        wait_drain();
        if (mode == READY_RANDOM)
            check_value("in_ready stall seen", stall_seen, 1'b1);
        ready_mode <= READY_ALWAYS;
    endtask

    task automatic test_reset_mid_traffic;
        ready_mode <= READY_HOLD;
        // Two beats of an unfinished packet stay inside
        send_beat(make_beat(1'b0, 5'd31));
        send_beat(make_beat(1'b0, 5'd31));
        idle_input();
        repeat (3) @(negedge clk);
        check_value("out_valid", out_valid, 1'b1);
        check_value("out_beat_count", out_beat_count, observed_count);
        reset = 1'b1;
        repeat (10) @(negedge clk);
        check_value("out_valid", out_valid, 1'b0);
        check_value("out_beat_count", out_beat_count, 32'd0);
        check_value("in_ready", in_ready, 1'b0);
        expected_q.delete();
        observed_count = 0;
        reset = 1'b0;
        ready_mode <= READY_ALWAYS;
        send_packet(3, 5'd9);
        idle_input();
        wait_drain();
        check_value("out_beat_count", out_beat_count, 32'd3);
    endtask

    //////////////////////////////////////////////////
    // Sequence and watchdog
    //////////////////////////////////////////////////

    initial
    begin
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_beat   = '0;
        out_ready = 1'b0;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        check_value("in_ready", in_ready, 1'b0);
        check_value("out_valid", out_valid, 1'b0);
        check_value("out_beat_count", out_beat_count, 32'd0);

        test_full_packet();
        test_flush_words();
        test_random_packets(READY_ALWAYS);
        test_random_packets(READY_RANDOM);
        test_reset_mid_traffic();

        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, dut.u_assert.failures);
        if (errors == 0 && dut.u_assert.failures == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

    initial
    begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timed out after %0d cycles with %0d beats still expected",
                 TIMEOUT_CYCLES, expected_q.size());
        $display("TEST FAIL");
        $finish;
    end

endmodule

//--- verilog/beat_reassembler.sv
// Rebuilds 32-byte beats from the word FIFO by joining the previous word with
// the head word. Phase-0 words are only stored, others produce one beat each.
// Also counts delivered beats.

`timescale 1ns/1ps

module beat_reassembler
    import repack_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  buffer_word_t          rd_word,
    input  logic                  empty,
    input  logic                  out_ready,
    output logic                  rd_en,
    output logic                  out_valid,
    output stream_beat_t          out_beat,
    output logic [BEAT_BYTES-1:0] out_keep,
    output logic [31:0]           out_beat_count
);

    // Previous popped word
    logic [8*WORD_BYTES-1:0] prev_data;
    buffer_ctrl_t            prev_ctrl;

    logic head_pop;
    logic accept;

    //////////////////////////////////////////////////
    // Pop and handshake
    //////////////////////////////////////////////////

    // Phase-0 words move into prev without output
    assign head_pop  = !empty && (rd_word.ctrl.phase == PHASE_0);
    // Output needs a beat start in prev
    assign out_valid = !empty && (rd_word.ctrl.phase != PHASE_0) && prev_ctrl.head;
    assign accept    = out_valid && out_ready;
    assign rd_en     = head_pop || accept;

    // Low count+1 bytes, 31 - count equals ~count on 5 bits
    assign out_keep = {BEAT_BYTES{1'b1}} >> ~prev_ctrl.count;

    //////////////////////////////////////////////////
    // Beat join
    //////////////////////////////////////////////////

    always_comb
    begin
        // Beat tag comes from the word it started in
        out_beat.last  = prev_ctrl.last;
        out_beat.count = prev_ctrl.count;

        case (rd_word.ctrl.phase)
            // All 24 bytes of prev, 8 bytes of current
            PHASE_1: out_beat.data = {rd_word.data[63:0], prev_data};
            // Top 16 bytes of prev, 16 of current
            PHASE_2: out_beat.data = {rd_word.data[127:0], prev_data[191:64]};
            // Top 8 bytes of prev, whole current word
            PHASE_3: out_beat.data = {rd_word.data[191:0], prev_data[191:128]};
            default: out_beat.data = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // State
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            prev_ctrl      <= '0;
            out_beat_count <= '0;
        end
        else
        begin
            if (rd_en)
            begin
                prev_ctrl <= rd_word.ctrl;
            end
            // One per accepted output beat
            if (accept)
            begin
                out_beat_count <= out_beat_count + 1'b1;
            end
        end
    end

    // Previous word payload
    always_ff @(posedge clk)
    begin
        if (rd_en)
        begin
            prev_data <= rd_word.data;
        end
    end

endmodule

//--- verilog/beat_splitter.sv
// Cuts 32-byte input beats into tagged 24-byte buffer words for the word FIFO.
// Three beats fill four words. A packet ending early in a group gets a flush
// word. Input stalls for the second word and while the FIFO is almost full.

`timescale 1ns/1ps

module beat_splitter
    import repack_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         in_valid,
    input  stream_beat_t in_beat,
    input  logic         almost_full,
    output logic         in_ready,
    output logic         wr_en,
    output buffer_word_t wr_word
);

    // Beat position in the current group, same code as its first word phase
    logic [PHASE_BITS-1:0] grp;
    logic [PHASE_BITS-1:0] grp_next;

    // Leftover bytes of the previous beat, 8 or 16 of them
    logic [127:0] residue;
    logic [127:0] residue_next;

    // Second word of a two-word beat, sent one cycle after the first
    logic         pend_valid;
    buffer_word_t pend_word;
    logic         ready_r;

    logic         take;
    logic         two_words;
    buffer_ctrl_t head_ctrl;
    buffer_word_t first_word;
    buffer_word_t second_word;

    assign take     = in_valid && in_ready;
    assign in_ready = ready_r && !almost_full;

    //////////////////////////////////////////////////
    // Word building
    //////////////////////////////////////////////////

    always_comb
    begin
        // First word always starts this beat
        head_ctrl.head  = 1'b1;
        head_ctrl.last  = in_beat.last;
        head_ctrl.phase = grp;
        head_ctrl.count = in_beat.count;

        first_word.ctrl  = head_ctrl;
        first_word.data  = '0;
        // Second word starts no beat
        second_word.ctrl = '0;
        second_word.data = '0;

        residue_next = residue;
        grp_next     = PHASE_0;
        // Packet end forces a flush word
        two_words    = in_beat.last;

        case (grp)
            PHASE_1:
            begin
                // Beat 0 tail below beat 1 head
                first_word.data        = {in_beat.data[127:0], residue[63:0]};
                // Flush keeps beat 1 tail, zero above
                second_word.ctrl.phase = PHASE_2;
                second_word.data       = {64'b0, in_beat.data[255:128]};
                residue_next           = in_beat.data[255:128];
                grp_next               = in_beat.last ? PHASE_0 : PHASE_2;
            end
            PHASE_2:
            begin
                // Beat 1 tail below beat 2 first 8 bytes
                first_word.data        = {in_beat.data[63:0], residue};
                // Rest of beat 2 fills a whole word
                second_word.ctrl.phase = PHASE_3;
                second_word.data       = in_beat.data[255:64];
                two_words              = 1'b1;
            end
            default:
            begin
                // Group start, low 24 bytes of beat 0
                first_word.data        = in_beat.data[191:0];
                second_word.ctrl.phase = PHASE_1;
                second_word.data       = {128'b0, in_beat.data[255:192]};
                residue_next           = {64'b0, in_beat.data[255:192]};
                grp_next               = in_beat.last ? PHASE_0 : PHASE_1;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // Control state
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            grp        <= PHASE_0;
            pend_valid <= 1'b0;
            ready_r    <= 1'b0;
            wr_en      <= 1'b0;
        end
        else
        begin
            // One write per taken beat, one more for its second word
            wr_en      <= take || pend_valid;
            pend_valid <= take && two_words;
            // Hold input off while the second word goes out
            ready_r    <= !(take && two_words);
            if (take)
            begin
                grp <= grp_next;
            end
        end
    end

    // Payload registers
    always_ff @(posedge clk)
    begin
        if (take)
        begin
            wr_word   <= first_word;
            pend_word <= second_word;
            residue   <= residue_next;
        end
        else if (pend_valid)
        begin
            wr_word <= pend_word;
        end
    end

endmodule

//--- verilog/repack_pkg.sv
// Shared widths, phase codes and record types for the 32-byte to 24-byte
// repacking path. Imported by the splitter, FIFO, reassembler and top level.

package repack_pkg;

    //////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////

    // Bytes per stream beat and per buffer word
    localparam int BEAT_BYTES = 32;
    localparam int WORD_BYTES = 24;

    // Control field carried beside each buffer word
    localparam int CTRL_BITS  = 9;
    localparam int PHASE_BITS = 2;
    localparam int COUNT_BITS = 5;

    // Flat width of one stored word
    localparam int WORD_BITS = 8 * WORD_BYTES + CTRL_BITS;

    // Word FIFO geometry
    localparam int FIFO_DEPTH     = 16;
    localparam int FIFO_ALMOST    = 3;
    localparam int FIFO_ADDR_BITS = $clog2(FIFO_DEPTH);

    // Packing phases within a three-beat group
    localparam logic [PHASE_BITS-1:0] PHASE_0 = 2'd0;
    localparam logic [PHASE_BITS-1:0] PHASE_1 = 2'd1;
    localparam logic [PHASE_BITS-1:0] PHASE_2 = 2'd2;
    localparam logic [PHASE_BITS-1:0] PHASE_3 = 2'd3;

    //////////////////////////////////////////////////
    // Records
    //////////////////////////////////////////////////

    // One stream beat, count is valid bytes minus one
    typedef struct packed {
        logic [8*BEAT_BYTES-1:0] data;
        logic                    last;
        logic [COUNT_BITS-1:0]   count;
    } stream_beat_t;

    // Tag of a buffer word
    typedef struct packed {
        logic                  head;
        logic                  last;
        logic [PHASE_BITS-1:0] phase;
        logic [COUNT_BITS-1:0] count;
    } buffer_ctrl_t;

    typedef struct packed {
        logic [8*WORD_BYTES-1:0] data;
        buffer_ctrl_t            ctrl;
    } buffer_word_t;

endpackage

//--- verilog/repack_top.sv
// Top of the repacking path. Splitter writes tagged words into the FIFO,
// reassembler drains it and rebuilds the original beats.
// Stream in on in_*, stream out on out_*.

`timescale 1ns/1ps

module repack_top
    import repack_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    input  stream_beat_t          in_beat,
    input  logic                  out_ready,
    output logic                  in_ready,
    output logic                  out_valid,
    output stream_beat_t          out_beat,
    output logic [BEAT_BYTES-1:0] out_keep,
    output logic [31:0]           out_beat_count
);

    //////////////////////////////////////////////////
    // Internal links
    //////////////////////////////////////////////////

    // Splitter to FIFO
    logic         wr_en;
    buffer_word_t wr_word;
    logic         almost_full;

    // FIFO to reassembler
    buffer_word_t rd_word;
    logic         empty;
    logic         rd_en;

    //////////////////////////////////////////////////
    // Blocks
    //////////////////////////////////////////////////

    beat_splitter u_splitter (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_beat     (in_beat),
        .almost_full (almost_full),
        .in_ready    (in_ready),
        .wr_en       (wr_en),
        .wr_word     (wr_word)
    );

    word_fifo u_fifo (
        .clk         (clk),
        .reset       (reset),
        .wr_en       (wr_en),
        .wr_word     (wr_word),
        .rd_en       (rd_en),
        .rd_word     (rd_word),
        .empty       (empty),
        .almost_full (almost_full)
    );

    beat_reassembler u_reassembler (
        .clk            (clk),
        .reset          (reset),
        .rd_word        (rd_word),
        .empty          (empty),
        .out_ready      (out_ready),
        .rd_en          (rd_en),
        .out_valid      (out_valid),
        .out_beat       (out_beat),
        .out_keep       (out_keep),
        .out_beat_count (out_beat_count)
    );

endmodule

//--- verilog/word_fifo.sv
// Single-clock FIFO of tagged buffer words between splitter and reassembler.
// Head entry shows ahead on rd_word, rd_en pops it.
// almost_full leaves room for words already in flight from the splitter.

`timescale 1ns/1ps

module word_fifo
    import repack_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         wr_en,
    input  buffer_word_t wr_word,
    input  logic         rd_en,
    output buffer_word_t rd_word,
    output logic         empty,
    output logic         almost_full
);

    // Storage, flat words
    logic [WORD_BITS-1:0] mem [FIFO_DEPTH];

    logic [FIFO_ADDR_BITS-1:0] wr_ptr;
    logic [FIFO_ADDR_BITS-1:0] rd_ptr;
    // Occupancy, one bit wider than the pointers
    logic [FIFO_ADDR_BITS:0]   level;

    logic full;
    logic do_write;
    logic do_read;

    assign empty       = (level == 0);
    assign full        = (level == FIFO_DEPTH);
    // Rises with FIFO_ALMOST or fewer free entries
    assign almost_full = (level >= FIFO_DEPTH - FIFO_ALMOST);

    // Reads only with data, writes only with room
    assign do_read  = rd_en && !empty;
    assign do_write = wr_en && (!full || do_read);

    // Show-ahead head entry
    assign rd_word = mem[rd_ptr];

    //////////////////////////////////////////////////
    // Pointers and level
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end
        else
        begin
            // Depth is a power of two, pointers wrap on their own
            if (do_write)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    // Storage write
    always_ff @(posedge clk)
    begin
        if (do_write)
        begin
            mem[wr_ptr] <= wr_word;
        end
    end

endmodule
